// ==== prml_params.svh ====
// PR4 Viterbi detector sizes, traceback depth, lock count and register reset values
`ifndef PRML_PARAMS_SVH
`define PRML_PARAMS_SVH

// ==========================================================================
// Datapath widths
// ==========================================================================
// Signed equalized sample from the read channel front end
`define PRML_SAMPLE_WIDTH 10
// Branch and path metrics
`define PRML_METRIC_WIDTH 16

// Survivor history walked on every traceback
`define PRML_TRACEBACK_LEN 32
`define PRML_PTR_WIDTH 5

// Consecutive low-metric steps before lock is declared
`define PRML_SYNC_COUNT 64

// ==========================================================================
// Configuration register defaults
// ==========================================================================
`define PRML_LEVEL_NEG2_RST (-200)
`define PRML_LEVEL_ZERO_RST 0
`define PRML_LEVEL_POS2_RST 200
`define PRML_LOCK_THRESHOLD_RST 1000

`endif

// ==== prml_pkg.sv ====
// Shared sample, metric, survivor and trellis state types for the PR4 detector
`include "prml_params.svh"

package prml_pkg;

    // Equalized sample and expected levels
    typedef logic signed [`PRML_SAMPLE_WIDTH-1:0] sample_t;

    // Branch and path metrics, unsigned squared error
    typedef logic [`PRML_METRIC_WIDTH-1:0] metric_t;

    // One ACS decision per state
    // Bit i set when state i took its second predecessor
    typedef logic [3:0] survivor_t;

    // Trellis state as {newest bit, previous bit}
    // Channel output is newest minus the bit before previous
    //   ST_00 <- ST_00 (0)  or ST_01 (-2)
    //   ST_01 <- ST_10 (0)  or ST_11 (-2)
    //   ST_10 <- ST_00 (+2) or ST_01 (0)
    //   ST_11 <- ST_10 (+2) or ST_11 (0)
    typedef enum logic [1:0] {
        ST_00 = 2'b00,
        ST_01 = 2'b01,
        ST_10 = 2'b10,
        ST_11 = 2'b11
    } pr4_state_t;

endpackage

// ==== prml_config_regs.sv ====
// PR4 detector configuration registers holding the reference levels and lock threshold
`timescale 1ns/1ps
`include "prml_params.svh"

module prml_config_regs (
    input  logic                clk,
    input  logic                reset_n,

    // Host write port
    input  logic                cfg_write,
    input  logic [1:0]          cfg_addr,
    input  logic [15:0]         cfg_data,

    // Settings to the datapath
    output prml_pkg::sample_t   level_neg2,
    output prml_pkg::sample_t   level_zero,
    output prml_pkg::sample_t   level_pos2,
    output prml_pkg::metric_t   lock_threshold
);

    // ======================================================================
    // Register map
    // ======================================================================
    // 0 level_neg2, 1 level_zero, 2 level_pos2, 3 lock_threshold
    localparam logic [1:0] ADDR_NEG2 = 2'd0;
    localparam logic [1:0] ADDR_ZERO = 2'd1;
    localparam logic [1:0] ADDR_POS2 = 2'd2;
    localparam logic [1:0] ADDR_LOCK = 2'd3;

    // Levels take the low sample-width bits of the write data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            level_neg2     <= prml_pkg::sample_t'(`PRML_LEVEL_NEG2_RST);
            level_zero     <= prml_pkg::sample_t'(`PRML_LEVEL_ZERO_RST);
            level_pos2     <= prml_pkg::sample_t'(`PRML_LEVEL_POS2_RST);
            lock_threshold <= prml_pkg::metric_t'(`PRML_LOCK_THRESHOLD_RST);
        end else if (cfg_write) begin
            // One register per strobe, visible next cycle
            case (cfg_addr)
                ADDR_NEG2: level_neg2     <= cfg_data[`PRML_SAMPLE_WIDTH-1:0];
                ADDR_ZERO: level_zero     <= cfg_data[`PRML_SAMPLE_WIDTH-1:0];
                ADDR_POS2: level_pos2     <= cfg_data[`PRML_SAMPLE_WIDTH-1:0];
                ADDR_LOCK: lock_threshold <= cfg_data;
                default:   lock_threshold <= lock_threshold;
            endcase
        end
    end

endmodule

// ==== prml_branch_metric.sv ====
// PR4 branch metric pipeline computing truncated squared errors against three levels
`timescale 1ns/1ps
`include "prml_params.svh"

module prml_branch_metric (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                enable,
    input  prml_pkg::sample_t   sample_in,
    input  logic                sample_valid,
    input  prml_pkg::sample_t   level_neg2,
    input  prml_pkg::sample_t   level_zero,
    input  prml_pkg::sample_t   level_pos2,
    output prml_pkg::metric_t   bm_neg2,
    output prml_pkg::metric_t   bm_zero,
    output prml_pkg::metric_t   bm_pos2,
    output logic                bm_valid
);

    localparam int W = `PRML_SAMPLE_WIDTH;
    localparam int M = `PRML_METRIC_WIDTH;

    // Stage 1 differences, one bit wider than a sample
    logic signed [W:0]      diff_neg2, diff_zero, diff_pos2;
    logic                   diff_valid;
    // Full signed squares
    logic signed [2*W+1:0]  sq_neg2, sq_zero, sq_pos2;

    always_comb begin
        sq_neg2 = diff_neg2 * diff_neg2;
        sq_zero = diff_zero * diff_zero;
        sq_pos2 = diff_pos2 * diff_pos2;
    end

    // ======================================================================
    // Data stages
    // ======================================================================
    always_ff @(posedge clk) begin
        if (enable && sample_valid) begin
            diff_neg2 <= sample_in - level_neg2;
            diff_zero <= sample_in - level_zero;
            diff_pos2 <= sample_in - level_pos2;
        end
        // Keep the top metric bits of the 2W-bit square
        if (enable && diff_valid) begin
            bm_neg2 <= sq_neg2[2*W-1 -: M];
            bm_zero <= sq_zero[2*W-1 -: M];
            bm_pos2 <= sq_pos2[2*W-1 -: M];
        end
    end

    // Valid follows the two data stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            diff_valid <= 1'b0;
            bm_valid   <= 1'b0;
        end else if (enable) begin
            diff_valid <= sample_valid;
            bm_valid   <= diff_valid;
        end
    end

endmodule

// ==== prml_acs.sv ====
// PR4 add-compare-select over four states with per-step path metric normalization
`timescale 1ns/1ps
`include "prml_params.svh"

module prml_acs (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable,
    input  prml_pkg::metric_t       bm_neg2,
    input  prml_pkg::metric_t       bm_zero,
    input  prml_pkg::metric_t       bm_pos2,
    input  logic                    bm_valid,
    output prml_pkg::metric_t       path_metric [4],
    output prml_pkg::survivor_t     survivors,
    output logic                    step_valid,
    output prml_pkg::metric_t       min_path_metric
);

    // One guard bit on every sum
    localparam int SW = `PRML_METRIC_WIDTH + 1;

    logic [SW-1:0]          cand0 [4];
    logic [SW-1:0]          cand1 [4];
    logic [SW-1:0]          pm_sel [4];
    logic [SW-1:0]          pm_min;
    prml_pkg::metric_t      pm_next [4];
    prml_pkg::metric_t      min_next;
    prml_pkg::survivor_t    surv_next;

    // ======================================================================
    // Add, compare, select
    // ======================================================================
    // State s = {x, a} is reached from {a, 0} and {a, 1}
    // Output is x minus the oldest bit, so x = 1 gives +2 or 0, x = 0 gives 0 or -2
    always_comb begin
        logic [SW-1:0] norm;
        for (int s = 0; s < 4; s++) begin
            cand0[s] = {1'b0, path_metric[2 * (s % 2)]}
                     + {1'b0, (s >= 2) ? bm_pos2 : bm_zero};
            cand1[s] = {1'b0, path_metric[2 * (s % 2) + 1]}
                     + {1'b0, (s >= 2) ? bm_zero : bm_neg2};
            // Tie keeps the first predecessor
            surv_next[s] = (cand1[s] < cand0[s]);
            pm_sel[s]    = surv_next[s] ? cand1[s] : cand0[s];
        end

        // Step minimum is the best path's increment
        pm_min = pm_sel[0];
        for (int s = 1; s < 4; s++) begin
            if (pm_sel[s] < pm_min) begin
                pm_min = pm_sel[s];
            end
        end

        // Subtract the minimum, saturate anything past the metric range
        for (int s = 0; s < 4; s++) begin
            norm = pm_sel[s] - pm_min;
            pm_next[s] = norm[SW-1] ? '1 : norm[SW-2:0];
        end
        min_next = pm_min[SW-1] ? '1 : pm_min[SW-2:0];
    end

    // ======================================================================
    // Path metric registers
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < 4; s++) begin
                path_metric[s] <= '0;
            end
            min_path_metric <= '0;
            step_valid      <= 1'b0;
        end else if (enable) begin
            step_valid <= bm_valid;
            if (bm_valid) begin
                for (int s = 0; s < 4; s++) begin
                    path_metric[s] <= pm_next[s];
                end
                min_path_metric <= min_next;
            end
        end
    end

    // Decision word rides along with the metrics
    always_ff @(posedge clk) begin
        if (enable && bm_valid) begin
            survivors <= surv_next;
        end
    end

endmodule

// ==== prml_traceback.sv ====
// PR4 survivor ring and traceback FSM emitting one decided bit per traceback
`timescale 1ns/1ps
`include "prml_params.svh"

module prml_traceback (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable,
    input  prml_pkg::survivor_t     survivors,
    input  logic                    step_valid,
    input  prml_pkg::metric_t       path_metric [4],
    output logic                    bit_out,
    output logic                    bit_valid
);

    localparam int L  = `PRML_TRACEBACK_LEN;
    localparam int PW = `PRML_PTR_WIDTH;
    // Ring spans two traceback lengths so new steps never overwrite a word still to be walked
    localparam int RING_DEPTH = 2 * L;

    typedef enum logic {
        TB_IDLE,
        TB_TRACE
    } tb_fsm_t;

    prml_pkg::survivor_t    ring [RING_DEPTH];
    logic [PW:0]            wr_ptr;
    logic [PW:0]            rd_ptr;
    logic                   filled;
    tb_fsm_t                fsm;
    logic [PW-1:0]          walk_cnt;
    prml_pkg::pr4_state_t   tb_state;
    prml_pkg::pr4_state_t   best_state;
    prml_pkg::pr4_state_t   prev_state;
    prml_pkg::survivor_t    rd_word;
    logic                   decided_bit;
    logic                   decided_valid;

    // ======================================================================
    // Survivor ring
    // ======================================================================
    always_ff @(posedge clk) begin
        if (enable && step_valid) begin
            ring[wr_ptr] <= survivors;
        end
    end

    // Fill flag rises once L steps have been stored
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            filled <= 1'b0;
        end else if (enable && step_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_ptr == (PW+1)'(L - 1)) begin
                filled <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Start state and backward step
    // ======================================================================
    // Lowest metric wins, ties to the lower state number
    always_comb begin
        prml_pkg::metric_t best_m;
        best_m     = path_metric[0];
        best_state = prml_pkg::ST_00;
        for (int s = 1; s < 4; s++) begin
            if (path_metric[s] < best_m) begin
                best_m     = path_metric[s];
                best_state = prml_pkg::pr4_state_t'(s[1:0]);
            end
        end
    end

    // Predecessor of {x, a} is {a, survivor bit}
    always_comb begin
        rd_word    = ring[rd_ptr];
        prev_state = prml_pkg::pr4_state_t'({tb_state[0], rd_word[tb_state]});
    end

    // ======================================================================
    // Traceback FSM
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fsm           <= TB_IDLE;
            tb_state      <= prml_pkg::ST_00;
            rd_ptr        <= '0;
            walk_cnt      <= '0;
            decided_bit   <= 1'b0;
            decided_valid <= 1'b0;
            bit_out       <= 1'b0;
            bit_valid     <= 1'b0;
        end else if (enable) begin
            decided_valid <= 1'b0;
            bit_valid     <= decided_valid;
            if (decided_valid) begin
                bit_out <= decided_bit;
            end
            case (fsm)
                TB_IDLE: begin
                    if (filled) begin
                        // Metrics belong to the step being written on this edge, if any
                        tb_state <= best_state;
                        rd_ptr   <= step_valid ? wr_ptr : wr_ptr - 1'b1;
                        walk_cnt <= PW'(L - 1);
                        fsm      <= TB_TRACE;
                    end
                end
                TB_TRACE: begin
                    tb_state <= prev_state;
                    rd_ptr   <= rd_ptr - 1'b1;
                    if (walk_cnt == '0) begin
                        // Newest bit of the state before the oldest word walked
                        decided_bit   <= prev_state[1];
                        decided_valid <= 1'b1;
                        fsm           <= TB_IDLE;
                    end else begin
                        walk_cnt <= walk_cnt - 1'b1;
                    end
                end
                default: fsm <= TB_IDLE;
            endcase
        end
    end

endmodule

// ==== prml_sync_detect.sv ====
// PR4 sync lock detector counting consecutive low best-path increments
`timescale 1ns/1ps
`include "prml_params.svh"

module prml_sync_detect (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                enable,
    input  logic                step_valid,
    input  prml_pkg::metric_t   min_path_metric,
    input  prml_pkg::metric_t   lock_threshold,
    output logic                sync_locked
);

    localparam int CW = $clog2(`PRML_SYNC_COUNT + 1);

    // Saturates at the lock count
    logic [CW-1:0] low_count;

    // ======================================================================
    // Lock counter
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            low_count   <= '0;
            sync_locked <= 1'b0;
        end else if (enable && step_valid) begin
            if (min_path_metric < lock_threshold) begin
                // Lock on the first low step after a full count
                if (low_count == CW'(`PRML_SYNC_COUNT)) begin
                    sync_locked <= 1'b1;
                end else begin
                    low_count <= low_count + 1'b1;
                end
            end else begin
                // Noisy step drops lock at once
                low_count   <= '0;
                sync_locked <= 1'b0;
            end
        end
    end

endmodule

// ==== prml_decoder.sv ====
// PR4 Viterbi read channel detector top with configuration registers
`timescale 1ns/1ps

module prml_decoder (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                enable,

    // Equalized samples
    input  prml_pkg::sample_t   sample_in,
    input  logic                sample_valid,

    // Configuration writes
    input  logic                cfg_write,
    input  logic [1:0]          cfg_addr,
    input  logic [15:0]         cfg_data,

    // Decisions and status
    output logic                bit_out,
    output logic                bit_valid,
    output prml_pkg::metric_t   min_path_metric,
    output logic                sync_locked
);

    prml_pkg::sample_t      level_neg2, level_zero, level_pos2;
    prml_pkg::metric_t      lock_threshold;
    prml_pkg::metric_t      bm_neg2, bm_zero, bm_pos2;
    logic                   bm_valid;
    prml_pkg::metric_t      path_metric [4];
    prml_pkg::survivor_t    survivors;
    logic                   step_valid;

    // ======================================================================
    // Settings and datapath
    // ======================================================================
    prml_config_regs config0 (
        .clk(clk), .reset_n(reset_n),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .level_neg2(level_neg2), .level_zero(level_zero), .level_pos2(level_pos2),
        .lock_threshold(lock_threshold)
    );

    prml_branch_metric bm0 (
        .clk(clk), .reset_n(reset_n), .enable(enable),
        .sample_in(sample_in), .sample_valid(sample_valid),
        .level_neg2(level_neg2), .level_zero(level_zero), .level_pos2(level_pos2),
        .bm_neg2(bm_neg2), .bm_zero(bm_zero), .bm_pos2(bm_pos2), .bm_valid(bm_valid)
    );

    prml_acs acs0 (
        .clk(clk), .reset_n(reset_n), .enable(enable),
        .bm_neg2(bm_neg2), .bm_zero(bm_zero), .bm_pos2(bm_pos2), .bm_valid(bm_valid),
        .path_metric(path_metric), .survivors(survivors),
        .step_valid(step_valid), .min_path_metric(min_path_metric)
    );

    // Decisions come out one traceback length behind the ACS
    prml_traceback tb0 (
        .clk(clk), .reset_n(reset_n), .enable(enable),
        .survivors(survivors), .step_valid(step_valid), .path_metric(path_metric),
        .bit_out(bit_out), .bit_valid(bit_valid)
    );

    prml_sync_detect sync0 (
        .clk(clk), .reset_n(reset_n), .enable(enable),
        .step_valid(step_valid), .min_path_metric(min_path_metric),
        .lock_threshold(lock_threshold), .sync_locked(sync_locked)
    );

endmodule

// ==== tb_prml_decoder.sv ====
// Self-checking testbench for the PR4 Viterbi detector driven by a PR4 channel model
`timescale 1ns/1ps
`include "prml_params.svh"

module tb_prml_decoder;

    localparam int L           = `PRML_TRACEBACK_LEN;
    localparam int SYNC        = `PRML_SYNC_COUNT;
    // Enabled cycles from a sample's input cycle to its decided bit
    localparam int LATENCY     = 2 * L + 5;
    localparam int N_CLEAN     = 600;
    localparam int N_RELOCK    = SYNC + 8;
    localparam int N_HOLD_RUN  = 150;
    localparam int N_CFG_RUN   = 400;
    localparam int HOLD_CYCLES = 20;
    localparam int MAX_SAMPLES = 2048;
    // All samples, hold and write cycles, plus room for the last tracebacks
    localparam int MAX_CYCLES  = 16 + N_CLEAN + 8 + N_RELOCK + N_HOLD_RUN + N_CFG_RUN
                               + 2 * HOLD_CYCLES + 8 + 4 * L;

    logic                   clk;
    logic                   reset_n;
    logic                   enable;
    prml_pkg::sample_t      sample_in;
    logic                   sample_valid;
    logic                   cfg_write;
    logic [1:0]             cfg_addr;
    logic [15:0]            cfg_data;
    logic                   bit_out;
    logic                   bit_valid;
    prml_pkg::metric_t      min_path_metric;
    logic                   sync_locked;

    // Channel model state and sent history, indexed by accepted sample
    prml_pkg::sample_t      lvl_neg2, lvl_zero, lvl_pos2;
    int                     noise_amp;
    logic                   nrz_hist [MAX_SAMPLES];
    logic                   clean_hist [MAX_SAMPLES];
    int                     n_sent;
    int                     n_bits;
    logic                   lock_check;
    int                     errors;
    int                     checks;
    int                     test_errors;
    int                     cycle_count = 0;

    prml_decoder dut0 (
        .clk(clk), .reset_n(reset_n), .enable(enable),
        .sample_in(sample_in), .sample_valid(sample_valid),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .bit_out(bit_out), .bit_valid(bit_valid),
        .min_path_metric(min_path_metric), .sync_locked(sync_locked)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hard stop on a hung run
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles without finishing", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ======================================================================
    // Checks and channel model
    // ======================================================================
    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Fail %0t: %s", $time, msg);
        end
    endtask

    // PR4 output is the bit minus the bit two places back
    function automatic prml_pkg::sample_t ideal_sample(input int k);
        int d;
        d = int'(nrz_hist[k]) - ((k >= 2) ? int'(nrz_hist[k - 2]) : 0);
        if (d > 0)
            return lvl_pos2;
        else if (d < 0)
            return lvl_neg2;
        return lvl_zero;
    endfunction

    // Outputs of enabled cycle t, where sample k is driven in cycle k
    task automatic check_cycle(input int t);
        if (bit_valid) begin
            n_bits++;
            // First two tracebacks start inside the reset transient
            if (n_bits > 2 && t >= LATENCY)
                check(bit_out === nrz_hist[t - LATENCY],
                      $sformatf("bit_out %0b, expected %0b for sample %0d",
                                bit_out, nrz_hist[t - LATENCY], t - LATENCY));
        end
        // Metric of the sample driven three cycles back
        if (t >= 7 && clean_hist[t - 3])
            check(min_path_metric == '0,
                  $sformatf("min_path_metric %0d on a clean step", min_path_metric));
        if (lock_check && t - 3 <= SYNC)
            check(sync_locked === 1'b0, "sync_locked high before the lock count");
        if (lock_check && t - 3 >= SYNC + 4)
            check(sync_locked === 1'b1, "sync_locked low after the lock count");
    endtask

    task automatic send_bit(input logic nrz, input logic glitch);
        int noise;
        nrz_hist[n_sent]   = nrz;
        clean_hist[n_sent] = !glitch;
        noise = (noise_amp > 0) ? int'($urandom_range(2 * noise_amp)) - noise_amp : 0;
        if (glitch)
            sample_in = prml_pkg::sample_t'(511);
        else
            sample_in = prml_pkg::sample_t'(int'(ideal_sample(n_sent)) + noise);
        sample_valid = 1'b1;
        @(posedge clk);
        #1;
        // Now inside the cycle after this sample's input cycle
        check_cycle(n_sent + 1);
        n_sent++;
    endtask

    task automatic send_random();
        send_bit(1'($urandom() % 2), 1'b0);
    endtask

    task automatic write_cfg(input logic [1:0] addr, input int value);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = 16'(value);
        @(posedge clk);
        #1;
        cfg_write = 1'b0;
    endtask

    // Freeze the detector and watch every output hold
    task automatic hold_enable(input int cycles);
        logic               held_bit;
        logic               held_lock;
        prml_pkg::metric_t  held_min;
        // A strobe in flight would stay frozen high
        while (bit_valid)
            send_random();
        held_bit  = bit_out;
        held_min  = min_path_metric;
        held_lock = sync_locked;
        enable    = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check(bit_valid === 1'b0, "bit_valid pulsed while enable was low");
            check(bit_out === held_bit && min_path_metric === held_min
                  && sync_locked === held_lock, "outputs changed while enable was low");
        end
        enable = 1'b1;
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        logic dropped;
        void'($urandom(32'h5c9f_3f40));
        reset_n      = 1'b0;
        enable       = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        lvl_neg2     = -200;
        lvl_zero     = 0;
        lvl_pos2     = 200;
        noise_amp    = 0;
        n_sent       = 0;
        n_bits       = 0;
        lock_check   = 1'b0;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
        enable  = 1'b1;

        // Clean data from reset, lock rises on schedule
        lock_check = 1'b1;
        repeat (N_CLEAN) send_random();
        lock_check = 1'b0;
        end_test("clean_decode");

        // Glitch on a +2 level sample so the true path stays best
        send_bit(1'b0, 1'b0);
        send_bit(1'b0, 1'b0);
        send_bit(1'b1, 1'b1);
        dropped = 1'b0;
        repeat (5) begin
            send_random();
            dropped |= !sync_locked;
        end
        check(dropped, "sync_locked did not drop after the +511 sample");
        repeat (N_RELOCK) send_random();
        check(sync_locked === 1'b1, "sync_locked did not return after clean data");
        end_test("lock_recovery");

        // Freeze, then resume with small noise that truncates away
        hold_enable(HOLD_CYCLES);
        noise_amp = 3;
        repeat (N_HOLD_RUN) send_random();
        noise_amp = 0;
        end_test("enable_hold");

        // Rescale levels while the datapath is frozen
        enable = 1'b0;
        write_cfg(2'd0, -100);
        write_cfg(2'd1, 0);
        write_cfg(2'd2, 100);
        lvl_neg2 = -100;
        lvl_pos2 = 100;
        enable   = 1'b1;
        repeat (N_CFG_RUN) send_random();
        end_test("config_change");

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
prml_pkg.sv
prml_config_regs.sv
prml_branch_metric.sv
prml_acs.sv
prml_traceback.sv
prml_sync_detect.sv
prml_decoder.sv
tb_prml_decoder.sv

// ==== Makefile ====
# Verilator build and run for the PR4 detector testbench
VERILATOR ?= verilator
TOP       ?= tb_prml_decoder
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
PASS_MSG  := Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) prml_params.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
